// File: common/bram_pkg.sv
// ====================
// Block memory geometry and types
// ====================

package bram_pkg;

  // Slice geometry, one word per entry
  localparam int unsigned MEM_DEPTH = 16384;
  localparam int unsigned MEM_AW    = $clog2(MEM_DEPTH); // 14 bits

  // Widest data path the request struct carries
  localparam int unsigned DATA_W_MAX = 32;

  // Request fanned out to every slice
  // Bit i of we and din belongs to slice i
  typedef struct packed {
    logic [MEM_AW-1:0]     addr; // Word address inside the slice
    logic [DATA_W_MAX-1:0] we;   // Per-bit write enable
    logic [DATA_W_MAX-1:0] din;  // Per-bit write data
  } mem_req_t;

  // Read in flight between issue and completion
  typedef struct packed {
    logic              valid; // Read issued this cycle
    logic [MEM_AW-1:0] addr;  // Address of the read, for debug
  } rd_tag_t;

endpackage

// File: bram/bram_prim_width.sv
// ====================
// One-bit RAM slice
// ====================

`timescale 1ns/1ps

module bram_prim_width
  import bram_pkg::*;
(
  input  logic              clka,
  input  logic [MEM_AW-1:0] addra,
  input  logic              dina,
  input  logic              wea,
  output logic              douta
);

  // Storage array, 16384 x 1
  logic mem [MEM_DEPTH];

  // Write or read, never both on one edge
  always_ff @(posedge clka) begin
    if (wea) begin
      mem[addra] <= dina; // Output keeps its old value
    end else begin
      douta <= mem[addra]; // One-cycle read
    end
  end

endmodule

// File: bram/bram_prim_width_sva.sv
// ====================
// Slice checker
// ====================

`timescale 1ns/1ps

module bram_prim_width_sva
  import bram_pkg::*;
(
  input logic              clka,
  input logic [MEM_AW-1:0] addra,
  input logic              dina,
  input logic              wea,
  input logic              douta
);

  // Shadow copy of the slice and map of written entries
  logic shadow  [MEM_DEPTH];
  bit   written [MEM_DEPTH];
  bit   started;   // First edge seen
  bit   started_q; // History valid for $past

  always_ff @(posedge clka) begin
    started   <= 1'b1;
    started_q <= started;
    if (!$isunknown(wea) && wea) begin
      shadow[addra]  <= dina;
      written[addra] <= 1'b1;
    end
  end

  default clocking cb @(posedge clka); endclocking

  // Controls must be defined
  a_wea_known: assert property (started |-> !$isunknown(wea))
    else $error("wea is X or Z");
  a_addr_known: assert property (started |-> !$isunknown(addra))
    else $error("addra has X or Z bits");

  // Write data defined when it is stored
  a_din_known: assert property (started && wea |-> !$isunknown(dina))
    else $error("dina is X or Z on a write");

  // No read during write
  a_wr_hold: assert property (started && wea |=> $stable(douta))
    else $error("douta changed on a write edge");

  // Read of a written entry returns the shadow value
  a_rd_data: assert property (started && !wea && written[addra]
                              |=> douta == $past(shadow[addra]))
    else $error("Read data mismatch");

  // Same address read twice in a row gives the same bit
  a_rd_repeat: assert property (started_q && !wea && $past(!wea) && addra == $past(addra)
                                |=> $stable(douta))
    else $error("Repeated read mismatch");

  // Access patterns
  c_wr:     cover property (started && wea);
  c_rd:     cover property (started && !wea);
  c_wr_wr:  cover property (started && wea ##1 wea);
  c_rd_rd:  cover property (started && !wea ##1 !wea);
  c_wr_rd:  cover property (started && wea ##1 (!wea && addra == $past(addra)));

endmodule

// Checker goes into every slice
bind bram_prim_width bram_prim_width_sva u_bram_prim_width_sva (
  .clka  (clka),
  .addra (addra),
  .dina  (dina),
  .wea   (wea),
  .douta (douta)
);

// File: src/apb_mem_port.sv
// ====================
// APB memory front-end
// ====================

`timescale 1ns/1ps

module apb_mem_port
  import bram_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16
) (
  input  logic                    clka,
  input  logic                    rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [ADDR_WIDTH-1:0]   paddr,   // Word address
  input  logic [DATA_WIDTH-1:0]   pwdata,
  input  logic [DATA_WIDTH/8-1:0] pstrb,
  output logic                    wr_ready, // Write or error completion
  output logic                    pslverr,
  output mem_req_t                req,
  output rd_tag_t                 rd_issue
);

  logic access;    // APB access phase
  logic pending;   // Read issued and waiting for the collector
  logic first_acc; // First cycle of the access phase
  logic in_range;
  logic do_wr;
  logic do_rd;

  assign access    = psel & penable;
  assign first_acc = access & ~pending;     // Issue once per transfer
  assign in_range  = (paddr < MEM_DEPTH);
  assign do_wr     = first_acc & pwrite & in_range;
  assign do_rd     = first_acc & ~pwrite & in_range;

  // Read always ends in the next cycle
  always_ff @(posedge clka) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= do_rd;
    end
  end

  // Zero-wait completion for writes and range errors
  assign wr_ready = first_acc & (pwrite | ~in_range);
  assign pslverr  = first_acc & ~in_range;

  // Request goes straight to the slices
  always_comb begin
    req      = '0;
    req.addr = paddr[MEM_AW-1:0];
    req.din  = DATA_W_MAX'(pwdata); // Upper bits zero for narrow builds
    for (int i = 0; i < DATA_WIDTH; i++) begin
      req.we[i] = do_wr & pstrb[i/8]; // Byte strobe to bit enable
    end
  end

  // Tag for the collector
  always_comb begin
    rd_issue.valid = do_rd;
    rd_issue.addr  = paddr[MEM_AW-1:0];
  end

  // Completion only inside the access phase
  a_ready_in_access: assert property (@(posedge clka) disable iff (rst)
    (wr_ready || pslverr) |-> access)
    else $error("Completion outside APB access phase");

endmodule

// File: src/bram_read_collect.sv
// ====================
// Read data collector
// ====================

`timescale 1ns/1ps

module bram_read_collect
  import bram_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clka,
  input  logic                  rst,
  input  rd_tag_t               rd_issue,
  input  logic [DATA_WIDTH-1:0] dout,     // Gathered slice outputs
  output logic                  rd_ready,
  output logic [DATA_WIDTH-1:0] prdata
);

  rd_tag_t tag_q; // Read one cycle old

  // Slices answer one edge after issue
  always_ff @(posedge clka) begin
    if (rst) begin
      tag_q.valid <= 1'b0;
    end else begin
      tag_q.valid <= rd_issue.valid;
    end
    tag_q.addr <= rd_issue.addr; // Debug only
  end

  assign rd_ready = tag_q.valid;
  assign prdata   = tag_q.valid ? dout : '0; // Zero outside a read

  // Single-beat completion
  a_no_double: assert property (@(posedge clka) disable iff (rst)
    rd_ready |=> !rd_ready)
    else $error("rd_ready high on consecutive cycles");

  // Issue and completion line up
  a_issue_to_ready: assert property (@(posedge clka) disable iff (rst)
    rd_issue.valid |=> rd_ready)
    else $error("Issued read did not complete");
  a_ready_from_issue: assert property (@(posedge clka) disable iff (rst)
    rd_ready |-> $past(rd_issue.valid))
    else $error("rd_ready without an issued read");

  // Completed read had a defined address
  a_tag_addr: assert property (@(posedge clka) disable iff (rst)
    rd_ready |-> !$isunknown(tag_q.addr))
    else $error("Read tag address unknown");

endmodule

// File: src/bram_apb_top.sv
// ====================
// APB block memory top
// ====================

`timescale 1ns/1ps

module bram_apb_top
  import bram_pkg::*;
#(
  parameter int DATA_WIDTH = 32, // Slice count and bus width
  parameter int ADDR_WIDTH = 16  // APB word address width
) (
  input  logic                    clka,
  input  logic                    rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [ADDR_WIDTH-1:0]   paddr,
  input  logic [DATA_WIDTH-1:0]   pwdata,
  input  logic [DATA_WIDTH/8-1:0] pstrb,
  output logic                    pready,
  output logic [DATA_WIDTH-1:0]   prdata,
  output logic                    pslverr
);

  mem_req_t              req;
  rd_tag_t               rd_tag;
  logic                  wr_ready;
  logic                  rd_ready;
  logic [DATA_WIDTH-1:0] dout;

  if (DATA_WIDTH > DATA_W_MAX || DATA_WIDTH % 8 != 0 || ADDR_WIDTH < MEM_AW) begin : g_bad_cfg
    $error("Unsupported DATA_WIDTH or ADDR_WIDTH");
  end

  apb_mem_port #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_port (
    .clka, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
    .wr_ready (wr_ready),
    .pslverr  (pslverr),
    .req      (req),
    .rd_issue (rd_tag)
  );

  // One primitive per data bit
  for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_slice
    bram_prim_width u_slice (
      .clka  (clka),
      .addra (req.addr),
      .dina  (req.din[i]),
      .wea   (req.we[i]),
      .douta (dout[i])
    );
  end

  bram_read_collect #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_collect (
    .clka, .rst,
    .rd_issue (rd_tag),
    .dout     (dout),
    .rd_ready (rd_ready),
    .prdata   (prdata)
  );

  assign pready = wr_ready | rd_ready; // Sources never overlap

endmodule

// File: test/tb_bram_apb_props.sv
// ====================
// APB port assertions
// ====================

`timescale 1ns/1ps

module tb_bram_apb_props #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 16
) (
  input logic                  clka,
  input logic                  rst,
  input logic                  psel,
  input logic                  penable,
  input logic                  pwrite,
  input logic [ADDR_WIDTH-1:0] paddr,
  input logic                  pready,
  input logic                  pslverr,
  input logic [DATA_WIDTH-1:0] prdata
);

  localparam int DEPTH = 16384; // Words in the memory

  int pass_cnt = 0;
  int fail_cnt = 0;

  // Quiet bus while reset holds, from the second edge on
  a_reset_quiet: assert property (@(posedge clka) rst ##1 rst |-> !pready && !pslverr)
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("pready or pslverr high during reset");
  end
  a_reset_exit: assert property (@(posedge clka) $fell(rst) |-> !pready && !pslverr)
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("pready or pslverr high right after reset");
  end

  // No completion outside a transfer or in setup
  a_idle_quiet: assert property (@(posedge clka) disable iff (rst)
    !psel || !penable |-> !pready && !pslverr)
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("completion outside the access phase");
  end
  a_err_ready: assert property (@(posedge clka) disable iff (rst) pslverr |-> pready)
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("pslverr raised without pready");
  end
  a_rdata_zero: assert property (@(posedge clka) disable iff (rst) !pready |-> prdata == '0)
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("prdata not zero while no transfer completes");
  end

  // Wait states per transfer kind
  a_wr_no_wait: assert property (@(posedge clka) disable iff (rst)
    (psel && !penable && pwrite && paddr < DEPTH) ##1 (psel && penable)
    |-> pready && !pslverr)
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("write did not complete in its first access cycle");
  end
  a_rd_one_wait: assert property (@(posedge clka) disable iff (rst)
    (psel && !penable && !pwrite && paddr < DEPTH) ##1 (psel && penable)
    |-> !pready ##1 (pready && !pslverr))
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("read did not complete in its second access cycle");
  end
  a_err_no_wait: assert property (@(posedge clka) disable iff (rst)
    (psel && !penable && paddr >= DEPTH) ##1 (psel && penable)
    |-> pready && pslverr && prdata == '0)
    pass_cnt++;
  else begin
    fail_cnt++;
    $error("out-of-range transfer gave no immediate pslverr");
  end

endmodule

bind bram_apb_top tb_bram_apb_props #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH))
  u_props (.*);

// File: test/tb_bram_apb.sv
// ====================
// APB block memory testbench
// ====================

`timescale 1ns/1ps

module tb_bram_apb;

  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 16;
  localparam int DEPTH      = 16384;          // Words per slice
  localparam int NSTRB      = DATA_WIDTH / 8;
  localparam int MAX_CYCLES = 4000;           // Tests need about 400, wide margin

  logic                  clka;
  logic                  rst;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [ADDR_WIDTH-1:0] paddr;
  logic [DATA_WIDTH-1:0] pwdata;
  logic [NSTRB-1:0]      pstrb;
  logic                  pready;
  logic [DATA_WIDTH-1:0] prdata;
  logic                  pslverr;

  logic [DATA_WIDTH-1:0] model [int]; // Expected memory contents
  integer seed;
  int     cycles     = 0;
  int     errs       = 0; // Errors of the running test
  int     props_base = 0; // Assertion failures before this test
  int     tests_pass = 0;
  int     tests_fail = 0;

  bram_apb_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_bram_apb_top (.*);

  initial clka = 1'b0;
  always #20 clka = ~clka; // 40 ns period

  // Run limit
  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check(string name, logic [DATA_WIDTH-1:0] exp, logic [DATA_WIDTH-1:0] got);
    assert (got === exp)
    else begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
      errs++;
    end
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_xfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data, input logic [NSTRB-1:0] strb,
                          output logic [DATA_WIDTH-1:0] rdata, output logic err,
                          output int waits);
    @(negedge clka);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(negedge clka);
    penable = 1'b1;
    waits   = 0;
    @(posedge clka); // Inputs settled since the falling edge
    while (pready !== 1'b1 && waits < 8) begin
      waits++;
      @(posedge clka);
    end
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      $display("Transfer to address %h never completed", addr);
      errs++;
    end
  endtask

  task automatic bus_idle(int n);
    repeat (n) begin
      @(negedge clka);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic do_write(input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data, input logic [NSTRB-1:0] strb);
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
    int                    waits;
    logic [DATA_WIDTH-1:0] word;
    apb_xfer(1'b1, addr, data, strb, rdata, err, waits);
    check("write wait states", 0, waits);
    check("pslverr", addr >= DEPTH, err);
    if (addr < DEPTH) begin
      word = model.exists(addr) ? model[addr] : 'x;
      for (int b = 0; b < NSTRB; b++) begin
        if (strb[b]) word[8*b +: 8] = data[8*b +: 8]; // Byte merge
      end
      model[addr] = word;
    end
  endtask

  task automatic do_read(input logic [ADDR_WIDTH-1:0] addr);
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
    int                    waits;
    apb_xfer(1'b0, addr, '0, '0, rdata, err, waits);
    if (addr < DEPTH) begin
      check("read wait states", 1, waits);
      check("pslverr", 0, err);
      check("prdata", model[addr], rdata);
    end else begin
      check("error wait states", 0, waits);
      check("pslverr", 1, err);
      check("prdata", 0, rdata);
    end
  endtask

  task automatic finish_test(string name);
    errs += i_bram_apb_top.u_props.fail_cnt - props_base; // Assertion failures too
    props_base = i_bram_apb_top.u_props.fail_cnt;
    $display("Test %-10s %s, %0d errors", name, errs == 0 ? "passed" : "failed", errs);
    if (errs == 0) tests_pass++;
    else tests_fail++;
    errs = 0;
  endtask

  initial begin
    logic [ADDR_WIDTH-1:0] addr_q [$];
    logic [ADDR_WIDTH-1:0] tmp;
    int                    j;
    seed    = 99933;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;

    // Reset, first edge loads the registers
    @(posedge clka);
    repeat (15) begin
      @(posedge clka);
      check("pready", 0, pready);
      check("pslverr", 0, pslverr);
    end
    @(negedge clka);
    rst = 1'b0;
    repeat (3) begin
      @(posedge clka);
      check("pready", 0, pready);
      check("pslverr", 0, pslverr);
    end
    finish_test("reset");

    do_write(16'h0005, 32'hA5A5_0F0F, 4'hF);
    do_read(16'h0005);
    do_write(DEPTH - 1, $random(seed), 4'hF); // Top word
    do_read(DEPTH - 1);
    bus_idle(1);
    finish_test("full_word");

    do_write(16'h0100, 32'h1122_3344, 4'hF);
    for (int s = 0; s < 16; s++) begin
      do_write(16'h0100, $random(seed), s[3:0]); // Every strobe pattern
      do_read(16'h0100);
    end
    bus_idle(1);
    finish_test("strobes");

    do_write(DEPTH, $random(seed), 4'hF);
    do_read(DEPTH + 7);
    do_write(16'hFFFF, $random(seed), 4'hF);
    do_read(16'hFFFF);
    foreach (model[a]) do_read(a); // Memory untouched by errors
    bus_idle(1);
    finish_test("range");

    repeat (40) begin
      tmp = $unsigned($random(seed)) % DEPTH;
      do_write(tmp, $random(seed), 4'hF);
      addr_q.push_back(tmp);
    end
    bus_idle(2);
    for (int i = addr_q.size() - 1; i > 0; i--) begin
      j         = $unsigned($random(seed)) % (i + 1); // Shuffle read order
      tmp       = addr_q[i];
      addr_q[i] = addr_q[j];
      addr_q[j] = tmp;
    end
    foreach (addr_q[i]) do_read(addr_q[i]); // No idle cycle between reads
    bus_idle(1);
    finish_test("random");

    $display("Tests passed %0d, failed %0d, assertion passes %0d",
             tests_pass, tests_fail, i_bram_apb_top.u_props.pass_cnt);
    if (tests_fail == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: sim.f
common/bram_pkg.sv
bram/bram_prim_width.sv
bram/bram_prim_width_sva.sv
src/apb_mem_port.sv
src/bram_read_collect.sv
src/bram_apb_top.sv
test/tb_bram_apb_props.sv
test/tb_bram_apb.sv

// File: Bender.yml
package:
  name: bram_apb

sources:
  - common/bram_pkg.sv
  - bram/bram_prim_width.sv
  - bram/bram_prim_width_sva.sv
  - src/apb_mem_port.sv
  - src/bram_read_collect.sv
  - src/bram_apb_top.sv
  - target: test
    files:
      - test/tb_bram_apb_props.sv
      - test/tb_bram_apb.sv
